//--- verilog/uart_pkg.sv
package uart_pkg;

	////////////////////////////////////////
	// serial bit timing
	////////////////////////////////////////

	// clock cycles per serial bit
	// kept small so simulation stays short
	localparam int CLKS_PER_BIT = 8;

	////////////////////////////////////////
	// fifo sizing
	////////////////////////////////////////

	// address width of one fifo
	localparam int FIFO_AW = 3;
	// entries per fifo
	localparam int FIFO_DEPTH = 1 << FIFO_AW;

	////////////////////////////////////////
	// register map
	////////////////////////////////////////

	localparam logic [31:0] ADDR_DATA = 32'h0000_0000;
	localparam logic [31:0] ADDR_STATUS = 32'h0000_0004;

	// status word bit positions
	localparam int ST_TX_FULL = 0;
	localparam int ST_RX_EMPTY = 1;
	// sticky, cleared by a status read
	localparam int ST_RX_OVERRUN = 2;
	localparam int ST_FRAME_ERR = 3;

	// axi response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- verilog/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
	parameter int DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] wdata,
	input  logic       pop,
	output logic [7:0] rdata,
	output logic       full,
	output logic       empty
);

	localparam int AW = $clog2(DEPTH);

	// storage, no reset needed
	logic [7:0] mem [DEPTH];
	// pointers carry one extra wrap bit
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	// ignore push when full and pop when empty
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// head entry visible without latency
	assign rdata = mem[rd_ptr[AW-1:0]];

	// same index, wrap bits tell full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fifo_empty,
	input  logic [7:0] fifo_rdata,
	output logic       fifo_pop,
	output logic       tx
);
	import uart_pkg::*;

	localparam int CW = $clog2(CLKS_PER_BIT);

	// fsm states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	logic [1:0]    state;
	logic [CW-1:0] cnt;
	logic [2:0]    bit_idx;
	logic [7:0]    shift;
	logic          bit_done;

	// last cycle of the current bit
	assign bit_done = (cnt == CW'(CLKS_PER_BIT - 1));

	// pop when idle or at the end of stop, so frames run back to back
	assign fifo_pop = !fifo_empty && ((state == S_IDLE) || (state == S_STOP && bit_done));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			shift <= '0;
			// line idles high
			tx <= 1'b1;
		end else if (fifo_pop) begin
			// load byte, start bit goes out next cycle
			state <= S_START;
			shift <= fifo_rdata;
			cnt <= '0;
			tx <= 1'b0;
		end else begin
			cnt <= bit_done ? '0 : cnt + 1'b1;
			case (state)
				S_START: begin
					if (bit_done) begin
						// first data bit, lsb first
						state <= S_DATA;
						bit_idx <= '0;
						tx <= shift[0];
						shift <= shift >> 1;
					end
				end
				S_DATA: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
							tx <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx <= shift[0];
							shift <= shift >> 1;
						end
					end
				end
				S_STOP: begin
					// nothing queued, back to idle
					if (bit_done)
						state <= S_IDLE;
				end
				default: begin
					tx <= 1'b1;
					cnt <= '0;
				end
			endcase
		end
	end

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output logic       push,
	output logic [7:0] wdata,
	input  logic       fifo_full,
	output logic       frame_err,
	output logic       overrun_evt
);
	import uart_pkg::*;

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam int HALF = CLKS_PER_BIT / 2;

	// fsm states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	// two flop synchronizer plus edge history
	logic          rx_meta;
	logic          rx_sync;
	logic          rx_prev;
	logic [1:0]    state;
	logic [CW-1:0] cnt;
	logic [2:0]    bit_idx;
	logic [7:0]    shift;
	logic          fall;
	logic          half_done;
	logic          bit_done;
	logic          stop_sample;

	assign fall = rx_prev && !rx_sync;
	// middle of start bit
	assign half_done = (cnt == CW'(HALF - 1));
	// one full bit later, middle of next bit
	assign bit_done = (cnt == CW'(CLKS_PER_BIT - 1));
	assign stop_sample = (state == S_STOP) && bit_done;

	////////////////////////////////////////
	// result of the stop bit sample
	////////////////////////////////////////

	// push only a good frame with room in the fifo
	assign push = stop_sample && rx_sync && !fifo_full;
	assign overrun_evt = stop_sample && rx_sync && fifo_full;
	// low stop bit, byte is dropped
	assign frame_err = stop_sample && !rx_sync;
	assign wdata = shift;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			shift <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (fall)
						state <= S_START;
				end
				S_START: begin
					cnt <= cnt + 1'b1;
					if (half_done) begin
						cnt <= '0;
						bit_idx <= '0;
						// high again means a glitch
						state <= rx_sync ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					cnt <= bit_done ? '0 : cnt + 1'b1;
					if (bit_done) begin
						// fill from the top, lsb ends up at bit 0
						shift <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end
				end
				default: begin
					cnt <= bit_done ? '0 : cnt + 1'b1;
					// leave at mid stop so the next edge is not missed
					if (bit_done)
						state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

//--- verilog/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
	input  logic        clk,
	input  logic        rst_n,
	// write address and data
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	// write response
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	// read address and data
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	// transmit fifo side
	output logic        tx_push,
	output logic [7:0]  tx_wdata,
	input  logic        tx_full,
	// receive fifo side
	output logic        rx_pop,
	input  logic [7:0]  rx_rdata,
	input  logic        rx_empty,
	// event pulses from the receiver
	input  logic        frame_err,
	input  logic        overrun_evt
);
	import uart_pkg::*;

	logic        wr_en;
	logic        rd_en;
	logic        wr_is_data;
	logic        wr_is_status;
	logic        rd_is_data;
	logic        rd_is_status;
	logic        clr_sticky;
	logic        overrun_q;
	logic        frame_err_q;
	logic [31:0] status_word;

	// transfer edges, ready only rises with valid already up
	assign wr_en = awready && awvalid && wvalid;
	assign rd_en = arready && arvalid;

	assign wr_is_data = (awaddr == ADDR_DATA);
	assign wr_is_status = (awaddr == ADDR_STATUS);
	assign rd_is_data = (araddr == ADDR_DATA);
	assign rd_is_status = (araddr == ADDR_STATUS);

	// full word taken, only low byte reaches the fifo
	assign tx_push = wr_en && wr_is_data && !tx_full;
	assign tx_wdata = wdata[7:0];
	assign rx_pop = rd_en && rd_is_data && !rx_empty;
	assign clr_sticky = rd_en && rd_is_status;

	always_comb begin
		status_word = '0;
		status_word[ST_TX_FULL] = tx_full;
		status_word[ST_RX_EMPTY] = rx_empty;
		status_word[ST_RX_OVERRUN] = overrun_q;
		status_word[ST_FRAME_ERR] = frame_err_q;
	end

	////////////////////////////////////////
	// handshake control
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// one cycle accept pulse, held off while a response waits
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready <= awvalid && wvalid && !bvalid && !awready;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			arready <= arvalid && !rvalid && !arready;
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// sticky flags, a set pulse beats the clearing read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			overrun_q <= 1'b0;
			frame_err_q <= 1'b0;
		end else begin
			overrun_q <= overrun_evt || (overrun_q && !clr_sticky);
			frame_err_q <= frame_err || (frame_err_q && !clr_sticky);
		end
	end

	////////////////////////////////////////
	// response payload
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			// full fifo drops the byte, unmapped gets slverr
			if (wr_is_data)
				bresp <= tx_full ? RESP_SLVERR : RESP_OKAY;
			else if (wr_is_status)
				bresp <= RESP_OKAY;
			else
				bresp <= RESP_SLVERR;
		end
		if (rd_en) begin
			if (rd_is_data && !rx_empty) begin
				rdata <= {24'd0, rx_rdata};
				rresp <= RESP_OKAY;
			end else if (rd_is_status) begin
				rdata <= status_word;
				rresp <= RESP_OKAY;
			end else begin
				// empty fifo or unmapped address
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps

module uart_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        rx,
	output logic        tx
);
	import uart_pkg::*;

	// transmit path
	logic       tx_push;
	logic [7:0] tx_wdata;
	logic       tx_full;
	logic       tx_empty;
	logic [7:0] tx_rdata;
	logic       tx_pop;
	// receive path
	logic       rx_push;
	logic [7:0] rx_wdata;
	logic       rx_full;
	logic       rx_empty;
	logic [7:0] rx_rdata;
	logic       rx_pop;
	// receiver events
	logic       frame_err;
	logic       overrun_evt;

	uart_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full),
		.rx_pop(rx_pop), .rx_rdata(rx_rdata), .rx_empty(rx_empty),
		.frame_err(frame_err), .overrun_evt(overrun_evt)
	);

	uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
		.rdata(tx_rdata), .full(tx_full), .empty(tx_empty)
	);

	uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
		.rdata(rx_rdata), .full(rx_full), .empty(rx_empty)
	);

	uart_tx u_tx (
		.clk(clk), .rst_n(rst_n),
		.fifo_empty(tx_empty), .fifo_rdata(tx_rdata), .fifo_pop(tx_pop),
		.tx(tx)
	);

	uart_rx u_rx (
		.clk(clk), .rst_n(rst_n), .rx(rx),
		.push(rx_push), .wdata(rx_wdata), .fifo_full(rx_full),
		.frame_err(frame_err), .overrun_evt(overrun_evt)
	);

endmodule

//--- tb/uart_checker.sv
`timescale 1ns/1ps

module uart_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        awready,
	input logic        wready,
	input logic        bvalid,
	input logic        bready,
	input logic [1:0]  bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [1:0]  rresp,
	input logic [31:0] rdata,
	input logic        tx
);
	import uart_pkg::*;

	// expectations queued by the testbench
	logic [1:0]  exp_b [$];
	logic [1:0]  exp_rr [$];
	logic [31:0] exp_rd [$];
	logic [7:0]  exp_tx [$];
	int          errors = 0;
	// tx line decoder
	logic        tx_prev;
	logic        busy;
	int          pos;
	int          idx;
	logic [7:0]  shreg;
	logic [7:0]  e_byte;
	logic [1:0]  e_resp;
	logic [31:0] e_data;

	task automatic expect_write(input logic [1:0] resp);
		exp_b.push_back(resp);
	endtask

	task automatic expect_read(input logic [1:0] resp, input logic [31:0] data);
		exp_rr.push_back(resp);
		exp_rd.push_back(data);
	endtask

	task automatic expect_frame(input logic [7:0] b);
		exp_tx.push_back(b);
	endtask

	function automatic int frames_left();
		return exp_tx.size();
	endfunction

	function automatic int pending();
		return exp_tx.size() + exp_b.size() + exp_rr.size();
	endfunction

	////////////////////////////////////////
	// axi responses
	////////////////////////////////////////

	always @(posedge clk) begin
		// address and data accepted in the same cycle
		if (rst_n && wready !== awready) begin
			$display("** Error: wready expected %h got %h", awready, wready);
			errors++;
		end
		if (rst_n && bvalid && bready) begin
			if (exp_b.size() == 0) begin
				$display("write response arrived with none expected");
				errors++;
			end else begin
				e_resp = exp_b.pop_front();
				if (bresp !== e_resp) begin
					$display("** Error: bresp expected %h got %h", e_resp, bresp);
					errors++;
				end
			end
		end
		if (rst_n && rvalid && rready) begin
			if (exp_rr.size() == 0) begin
				$display("read response arrived with none expected");
				errors++;
			end else begin
				e_resp = exp_rr.pop_front();
				e_data = exp_rd.pop_front();
				if (rresp !== e_resp) begin
					$display("** Error: rresp expected %h got %h", e_resp, rresp);
					errors++;
				end
				if (rdata !== e_data) begin
					$display("** Error: rdata expected %h got %h", e_data, rdata);
					errors++;
				end
			end
		end
	end

	////////////////////////////////////////
	// tx line, mid-bit sampling
	////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			tx_prev = 1'b1;
			busy = 1'b0;
			pos = 0;
		end else begin
			if (!busy) begin
				// start edge, count from here
				if (tx_prev && !tx) begin
					busy = 1'b1;
					pos = 1;
				end
			end else begin
				// every edge must sit on a bit boundary
				if (tx !== tx_prev && (pos % CLKS_PER_BIT) != 0) begin
					$display("tx bit time is not %0d cycles, edge at cycle %0d of frame",
						CLKS_PER_BIT, pos);
					errors++;
				end
				if ((pos % CLKS_PER_BIT) == CLKS_PER_BIT / 2) begin
					idx = pos / CLKS_PER_BIT;
					if (idx == 0 && tx !== 1'b0) begin
						$display("tx start bit not low at its middle");
						errors++;
					end else if (idx >= 1 && idx <= 8) begin
						shreg = {tx, shreg[7:1]};
					end else if (idx == 9) begin
						if (tx !== 1'b1) begin
							$display("tx stop bit not high at its middle");
							errors++;
						end
						if (exp_tx.size() == 0) begin
							$display("frame on tx with no byte expected");
							errors++;
						end else begin
							e_byte = exp_tx.pop_front();
							if (shreg !== e_byte) begin
								$display("** Error: tx byte expected %h got %h", e_byte, shreg);
								errors++;
							end
						end
					end
				end
				pos++;
				// frame ends after the full stop bit
				if (pos == 10 * CLKS_PER_BIT)
					busy = 1'b0;
			end
			tx_prev = tx;
		end
	end

endmodule

//--- tb/uart_asserts.sv
`timescale 1ns/1ps

module uart_asserts (
	input logic       clk,
	input logic       rst_n,
	input logic       tx,
	input logic [1:0] tx_state,
	input logic       awready,
	input logic       bvalid,
	input logic       bready,
	input logic       rvalid,
	input logic       rready,
	input logic       tx_full,
	input logic       tx_empty,
	input logic       rx_full,
	input logic       rx_empty
);

	// idle transmitter keeps the line high
	a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
		tx_state == 2'd0 |-> tx) else $error("tx low while transmitter idle");

	// responses hold until taken
	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	a_tx_flags: assert property (@(posedge clk) disable iff (!rst_n)
		!(tx_full && tx_empty)) else $error("tx fifo full and empty together");
	a_rx_flags: assert property (@(posedge clk) disable iff (!rst_n)
		!(rx_full && rx_empty)) else $error("rx fifo full and empty together");

	// no new write accepted with a response pending
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(awready) |-> !bvalid) else $error("awready rose with bvalid pending");

endmodule

bind uart_top uart_asserts u_asserts (
	.clk(clk), .rst_n(rst_n), .tx(tx), .tx_state(u_tx.state),
	.awready(awready), .bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready),
	.tx_full(tx_full), .tx_empty(tx_empty), .rx_full(rx_full), .rx_empty(rx_empty)
);

//--- tb/tb_uart.sv
`timescale 1ns/1ps

module tb_uart;
	import uart_pkg::*;

	// handshake wait limit in cycles
	localparam int TMO = 1000;

	logic        clk;
	logic        rst_n;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        rx;
	logic        tx;

	// receive side model
	logic [7:0]  rx_q [$];
	logic        ovr_pred;
	logic        fe_pred;
	logic [31:0] rng_state = 32'd80806;
	int          max_stall;
	int          timeouts;
	int          leftovers;

	uart_top DUT (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.rx(rx), .tx(tx)
	);

	uart_checker u_chk (
		.clk(clk), .rst_n(rst_n),
		.awready(awready), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.rvalid(rvalid), .rready(rready), .rresp(rresp), .rdata(rdata),
		.tx(tx)
	);

	// 4 ns period
	always #2 clk = ~clk;

	////////////////////////////////////////
	// random numbers
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r % n);
	endfunction

	task automatic note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
	endtask

	////////////////////////////////////////
	// axi master
	////////////////////////////////////////

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [1:0] resp);
		int n;
		u_chk.expect_write(resp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!(awready && wready) && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!(awready && wready))
			note_timeout("awready and wready");
		// transfer on the edge in between
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (rand_below(max_stall + 1)) @(negedge clk);
		bready = 1'b1;
		n = 0;
		while (!bvalid && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!bvalid)
			note_timeout("bvalid");
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, input logic [1:0] resp,
			input logic [31:0] data);
		int n;
		u_chk.expect_read(resp, data);
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!arready)
			note_timeout("arready");
		@(negedge clk);
		arvalid = 1'b0;
		repeat (rand_below(max_stall + 1)) @(negedge clk);
		rready = 1'b1;
		n = 0;
		while (!rvalid && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!rvalid)
			note_timeout("rvalid");
		@(negedge clk);
		rready = 1'b0;
	endtask

	// write a random byte that the fifo has room for
	task automatic write_byte();
		logic [31:0] r;
		r = next_rand();
		u_chk.expect_frame(r[7:0]);
		axi_write(ADDR_DATA, r, RESP_OKAY);
	endtask

	task automatic read_data();
		if (rx_q.size() > 0)
			axi_read(ADDR_DATA, RESP_OKAY, {24'd0, rx_q.pop_front()});
		else
			axi_read(ADDR_DATA, RESP_SLVERR, 32'd0);
	endtask

	// only called with the tx side drained, so tx_full is low
	task automatic read_status();
		logic [31:0] st;
		st = '0;
		st[ST_RX_EMPTY] = (rx_q.size() == 0);
		st[ST_RX_OVERRUN] = ovr_pred;
		st[ST_FRAME_ERR] = fe_pred;
		axi_read(ADDR_STATUS, RESP_OKAY, st);
		ovr_pred = 1'b0;
		fe_pred = 1'b0;
	endtask

	task automatic drain_tx();
		int n;
		n = 0;
		while (u_chk.frames_left() != 0 && n < 40 * CLKS_PER_BIT * FIFO_DEPTH) begin
			@(negedge clk);
			n++;
		end
		if (u_chk.frames_left() != 0)
			note_timeout("tx frames");
		// rest of the last stop bit
		repeat (2 * CLKS_PER_BIT) @(negedge clk);
	endtask

	////////////////////////////////////////
	// serial line driver
	////////////////////////////////////////

	task automatic send_frame(input logic [7:0] b, input logic bad_stop);
		rx = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		rx = !bad_stop;
		repeat (CLKS_PER_BIT) @(negedge clk);
		rx = 1'b1;
		if (bad_stop)
			fe_pred = 1'b1;
		else if (rx_q.size() < FIFO_DEPTH)
			rx_q.push_back(b);
		else
			ovr_pred = 1'b1;
		// idle gap, long enough for the sync chain
		repeat (2 + rand_below(2 * CLKS_PER_BIT)) @(negedge clk);
	endtask

	task automatic send_random(input logic bad_stop);
		logic [31:0] r;
		r = next_rand();
		send_frame(r[7:0], bad_stop);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rx = 1'b1;
		ovr_pred = 1'b0;
		fe_pred = 1'b0;
		max_stall = 3;
		timeouts = 0;
		leftovers = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);

		// transmit order and framing
		for (int i = 0; i < 6; i++)
			write_byte();
		drain_tx();

		// burst while the first frame is on the line
		max_stall = 1;
		write_byte();
		for (int i = 1; i <= FIFO_DEPTH + 2; i++) begin
			if (i <= FIFO_DEPTH)
				write_byte();
			else
				axi_write(ADDR_DATA, next_rand(), RESP_SLVERR);
		end
		drain_tx();

		// receive path
		max_stall = 3;
		for (int i = 0; i < 4; i++)
			send_random(1'b0);
		read_status();
		for (int i = 0; i < 5; i++)
			read_data();
		read_status();

		// overrun, second status shows it cleared
		for (int i = 0; i < FIFO_DEPTH + 2; i++)
			send_random(1'b0);
		read_status();
		for (int i = 0; i < FIFO_DEPTH; i++)
			read_data();
		read_status();

		// framing error then a good frame
		send_random(1'b1);
		send_random(1'b0);
		read_status();
		read_data();
		read_status();

		// decode and back-pressure
		max_stall = 8;
		axi_write(32'h0000_0008, next_rand(), RESP_SLVERR);
		axi_read(32'h0000_000c, RESP_SLVERR, 32'd0);
		axi_write(ADDR_STATUS, 32'h0000_000f, RESP_OKAY);
		read_status();
		send_random(1'b0);
		write_byte();
		read_data();
		read_data();
		drain_tx();
		read_status();

		repeat (10) @(negedge clk);
		leftovers = u_chk.pending();
		if (leftovers != 0)
			$display("%0d expected responses or frames never arrived", leftovers);
		$display("errors: %0d, timeouts: %0d", u_chk.errors + leftovers, timeouts);
		if (u_chk.errors == 0 && leftovers == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- filelist.f
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
tb/uart_checker.sv
tb/uart_asserts.sv
tb/tb_uart.sv

//--- run.sh
#!/bin/bash
# build and run the uart testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_uart -f filelist.f -o sim_uart \
	&& ./obj_dir/sim_uart > sim.log 2>&1 \
	|| echo "Test FAILED" >> sim.log

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
